/* src.f */
versat_pkg.sv
addr_gen.sv
mem_reader.sv
burst_writer.sv
dp_buffer.sv
vwrite_unit.sv
vwrite_top.sv
tb_databus_mem.sv
tb_vwrite.sv

/* tb_vwrite.sv */
module tb_vwrite;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 40;
   localparam int SEED       = 32'h05932472;
   // longest store, worst cycles per beat under stalls, most words per transfer
   localparam int STORE_MAX       = 1024 + 32;
   localparam int BEAT_MAX        = 20;
   localparam int WORDS_MAX       = 64;
   localparam int RUN_COUNT       = 9;
   localparam int WATCHDOG_CYCLES = 4 * RUN_COUNT * (STORE_MAX + BEAT_MAX * WORDS_MAX);

   typedef struct packed {
      logic [versat_pkg::EXT_ADDR_W-1:0] addr;
      logic [versat_pkg::LEN_W-1:0]      len;
      logic                              last;
      logic [versat_pkg::DATA_W/8-1:0]   strb;
      logic [versat_pkg::DATA_W-1:0]     data;
   } beat_t;

   logic                          clk;
   logic                          rst;
   logic                          run;
   logic                          running;
   logic                          ping_pong;
   logic                          clear_mem;
   logic                          rand_ready;
   versat_pkg::store_cfg_t        store_cfg;
   versat_pkg::xfer_cfg_t         xfer_cfg;
   logic [versat_pkg::DATA_W-1:0] in_data;
   logic                          done;
   versat_pkg::databus_req_t      bus_req;
   versat_pkg::databus_rsp_t      bus_rsp;

   // reference buffer contents, built from the loop and timing rules
   logic [versat_pkg::DATA_W-1:0] model_mem [1024];
   logic                          pp_model;
   beat_t                         exp_beat [1024];
   int                            exp_count;
   beat_t                         save_beat [1024];
   int                            save_count;
   logic [versat_pkg::DATA_W-1:0] tag;
   int                            cyc;
   string                         test_name;
   int                            test_errs;
   int                            tests_run;
   int                            tests_failed;
   int                            w;

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   vwrite_top dut_i (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run),
      .running_i   (running),
      .ping_pong_i (ping_pong),
      .store_cfg_i (store_cfg),
      .xfer_cfg_i  (xfer_cfg),
      .in_data_i   (in_data),
      .done_o      (done),
      .bus_req_o   (bus_req),
      .bus_rsp_i   (bus_rsp)
   );

   tb_databus_mem bus_mem (
      .clk          (clk),
      .rst          (rst),
      .clear_i      (clear_mem),
      .rand_ready_i (rand_ready),
      .req_i        (bus_req),
      .rsp_o        (bus_rsp)
   );

   function automatic versat_pkg::store_cfg_t make_store(input int start, input int per,
         input int incr, input int iter, input int shift, input int delay);
      versat_pkg::store_cfg_t s;
      s.start = start;
      s.per   = per;
      s.incr  = incr;
      s.iter  = iter;
      s.shift = shift;
      s.delay = delay;
      return s;
   endfunction

   function automatic versat_pkg::xfer_cfg_t make_xfer(input int ext, input int words,
         input int length, input logic enabled);
      versat_pkg::xfer_cfg_t x;
      x.ext_addr         = ext;
      x.amount_minus_one = words - 1;
      x.length           = length;
      x.enabled          = enabled;
      return x;
   endfunction

   function automatic beat_t rec_beat(input int idx);
      beat_t b;
      b.addr = bus_mem.rec_addr[idx];
      b.len  = bus_mem.rec_len[idx];
      b.last = bus_mem.rec_last[idx];
      b.strb = bus_mem.rec_strb[idx];
      b.data = bus_mem.rec_data[idx];
      return b;
   endfunction

   task automatic check_eq(input string what, input logic [31:0] expected,
         input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("FAILED %s %s: expected %h actual %h", test_name, what, expected, actual);
         test_errs++;
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      assert (cond) else begin
         $display("%s: %s", test_name, msg);
         test_errs++;
      end
   endtask

   task automatic check_beat(input string what, input int idx, input beat_t e, input beat_t a);
      check_eq($sformatf("%s beat %0d addr", what, idx), e.addr, a.addr);
      check_eq($sformatf("%s beat %0d len", what, idx), e.len, a.len);
      check_eq($sformatf("%s beat %0d last", what, idx), e.last, a.last);
      check_eq($sformatf("%s beat %0d strb", what, idx), e.strb, a.strb);
      check_eq($sformatf("%s beat %0d data", what, idx), e.data, a.data);
   endtask

   // one cycle, inputs change on the falling edge
   task automatic step();
      @(negedge clk);
      cyc++;
      run = 1'b0;
      clear_mem = 1'b0;
      in_data = tag + cyc;
   endtask

   // k-th store lands at start + j*incr + i*shift with the data of cycle delay+1+k
   task automatic apply_store(input versat_pkg::store_cfg_t s, input logic pp_on);
      int i;
      int j;
      int k;
      logic [versat_pkg::ADDR_W-1:0] a;
      k = 0;
      for (i = 0; i < int'(s.iter); i++) begin
         for (j = 0; j < int'(s.per); j++) begin
            a = s.start + j * s.incr + i * s.shift;
            if (pp_on) begin
               a[versat_pkg::ADDR_W-1] = pp_model;
            end
            model_mem[a] = tag + s.delay + 1 + k;
            k++;
         end
      end
   endtask

   task automatic build_expect(input versat_pkg::xfer_cfg_t x, input logic pp_on);
      int n;
      int lw;
      int b;
      int len;
      logic [versat_pkg::ADDR_W-1:0] a;
      n = int'(x.amount_minus_one) + 1;
      lw = int'(x.length);
      exp_count = x.enabled ? n : 0;
      for (w = 0; w < exp_count; w++) begin
         b = w / lw;
         len = (n - b * lw < lw) ? n - b * lw : lw;
         a = w;
         if (pp_on) begin
            a[versat_pkg::ADDR_W-1] = !pp_model;
         end
         exp_beat[w].data = model_mem[a];
         exp_beat[w].addr = x.ext_addr + versat_pkg::BYTES_PER_WORD * lw * b;
         exp_beat[w].len  = len;
         exp_beat[w].last = (w == b * lw + len - 1);
         exp_beat[w].strb = '1;
      end
   endtask

   // abort_beats >= 0 drops running after that many beats and skips the completion checks
   task automatic run_once(input versat_pkg::store_cfg_t s, input versat_pkg::xfer_cfg_t x,
         input logic pp_on, input logic rnd, input int abort_beats);
      int store_end;
      step();
      tag = $urandom();
      cyc = 0;
      in_data = tag;
      run = 1'b1;
      clear_mem = 1'b1;
      store_cfg = s;
      xfer_cfg = x;
      ping_pong = pp_on;
      rand_ready = rnd;
      pp_model = pp_on ? !pp_model : 1'b0;
      build_expect(x, pp_on);
      apply_store(s, pp_on);
      // cycle count when the last store is written
      store_end = int'(s.delay) + int'(s.per) * int'(s.iter);
      step();
      check_eq("done after run", 0, done);
      if (abort_beats >= 0) begin
         while (bus_mem.rec_count < abort_beats) begin
            step();
         end
         running = 1'b0;
         // stop reaches the unit on the next rising edge
         step();
         while (cyc <= store_end + 3) begin
            step();
         end
         check_eq("bus valid while stopped", 0, bus_req.valid);
         running = 1'b1;
      end else begin
         while (!done) begin
            step();
         end
         check_true(cyc > store_end, "done_o rose before the store loops finished");
         check_eq("beat count", exp_count, bus_mem.rec_count);
         if (!x.enabled) begin
            check_eq("bus valid cycles", 0, bus_mem.valid_cycles);
         end
         for (w = 0; w < exp_count && w < bus_mem.rec_count; w++) begin
            check_beat("bus", w, exp_beat[w], rec_beat(w));
         end
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("%s: pass", test_name);
      end else begin
         tests_failed++;
         $display("%s: %0d checks failed", test_name, test_errs);
      end
   endtask

   initial begin
      versat_pkg::store_cfg_t s;
      versat_pkg::xfer_cfg_t  x;
      void'($urandom(SEED));
      rst = 1'b1;
      run = 1'b0;
      running = 1'b1;
      ping_pong = 1'b0;
      clear_mem = 1'b0;
      rand_ready = 1'b0;
      store_cfg = '0;
      xfer_cfg = '0;
      in_data = '0;
      tag = '0;
      cyc = 0;
      pp_model = 1'b0;
      tests_run = 0;
      tests_failed = 0;
      repeat (2) @(negedge clk);
      rst = 1'b0;

      // whole buffer filled once so every later read has a known word
      start_test("reset_state");
      step();
      check_eq("done after reset", 1, done);
      check_eq("bus valid after reset", 0, bus_req.valid);
      run_once(make_store(0, 8, 1, 128, 8, 3), make_xfer(0, 16, 4, 1'b0), 1'b0, 1'b0, -1);
      end_test();

      start_test("ping_pong");
      run_once(make_store(3, 8, 4, 4, 1, 5), make_xfer(32'h2000, 32, 8, 1'b1), 1'b1, 1'b0, -1);
      run_once(make_store(0, 4, 1, 4, 4, 0), make_xfer(32'h3000, 40, 16, 1'b1), 1'b1, 1'b0, -1);
      end_test();

      start_test("burst_split");
      run_once(make_store(10, 5, 2, 3, 11, 2), make_xfer(32'h10000100, 23, 5, 1'b1),
               1'b1, 1'b0, -1);
      end_test();

      // same half read twice, stores go to the other half
      start_test("random_ready");
      s = make_store(600, 10, 2, 3, 40, 2);
      x = make_xfer(32'h4000, 50, 6, 1'b1);
      run_once(s, x, 1'b0, 1'b0, -1);
      save_count = bus_mem.rec_count;
      for (w = 0; w < save_count; w++) begin
         save_beat[w] = rec_beat(w);
      end
      run_once(s, x, 1'b0, 1'b1, -1);
      check_eq("replay beat count", save_count, bus_mem.rec_count);
      for (w = 0; w < save_count && w < bus_mem.rec_count; w++) begin
         check_beat("replay", w, save_beat[w], rec_beat(w));
      end
      end_test();

      start_test("xfer_disabled");
      run_once(make_store(100, 6, 1, 5, 7, 20), make_xfer(0, 16, 4, 1'b0), 1'b1, 1'b0, -1);
      end_test();

      start_test("abort_restart");
      run_once(make_store(0, 4, 1, 4, 4, 1), make_xfer(32'h5000, 64, 16, 1'b1), 1'b1, 1'b1, 10);
      run_once(make_store(40, 4, 3, 2, 1, 0), make_xfer(32'h6000, 64, 16, 1'b1),
               1'b1, 1'b1, -1);
      end_test();

      $display("tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
               tests_failed);
      if (tests_failed == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, a run never finished", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

endmodule

/* tb_databus_mem.sv */
module tb_databus_mem (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     clear_i,
   input  logic                     rand_ready_i,
   input  versat_pkg::databus_req_t req_i,
   output versat_pkg::databus_rsp_t rsp_o
);

   timeunit 1ns;
   timeprecision 1ps;

   logic [versat_pkg::DATA_W-1:0]     rec_data [1024];
   logic [versat_pkg::EXT_ADDR_W-1:0] rec_addr [1024];
   logic [versat_pkg::LEN_W-1:0]      rec_len  [1024];
   logic [versat_pkg::DATA_W/8-1:0]   rec_strb [1024];
   logic                              rec_last [1024];
   int                                rec_count = 0;
   int                                valid_cycles = 0;
   int                                beat_cnt = 0;
   int                                low_left = 0;
   logic                              rand_q = 1'b0;
   versat_pkg::databus_rsp_t          rsp_q = '0;

   assign rsp_o = rsp_q;

   // accepted beats, each with the burst it belongs to
   always @(posedge clk) begin
      rand_q = rand_ready_i;
      if (clear_i) begin
         rec_count = 0;
         valid_cycles = 0;
         beat_cnt = 0;
      end else begin
         if (req_i.valid) begin
            valid_cycles++;
         end
         if (req_i.valid && rsp_q.ready && rec_count < 1024) begin
            rec_data[rec_count] = req_i.wdata;
            rec_addr[rec_count] = req_i.addr;
            rec_len[rec_count]  = req_i.len;
            rec_strb[rec_count] = req_i.wstrb;
            rec_last[rec_count] = rsp_q.last;
            rec_count++;
            beat_cnt = rsp_q.last ? 0 : beat_cnt + 1;
         end
      end
   end

   // ready pattern, with stalls of several cycles now and then
   always @(negedge clk) begin
      if (rst) begin
         rsp_q.ready = 1'b0;
      end else if (!rand_q) begin
         rsp_q.ready = 1'b1;
      end else if (low_left > 0) begin
         rsp_q.ready = 1'b0;
         low_left--;
      end else if ($urandom_range(7) == 0) begin
         rsp_q.ready = 1'b0;
         low_left = 4 + $urandom_range(11);
      end else begin
         rsp_q.ready = ($urandom_range(3) != 0);
      end
      // final beat of the burst
      rsp_q.last = rsp_q.ready && (beat_cnt + 1 == int'(req_i.len));
   end

endmodule

/* vwrite_top.sv */
module vwrite_top (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run_i,
   input  logic                          running_i,
   input  logic                          ping_pong_i,
   input  versat_pkg::store_cfg_t        store_cfg_i,
   input  versat_pkg::xfer_cfg_t         xfer_cfg_i,
   input  logic [versat_pkg::DATA_W-1:0] in_data_i,
   output logic                          done_o,
   output versat_pkg::databus_req_t      bus_req_o,
   input  versat_pkg::databus_rsp_t      bus_rsp_i
);

   logic                          buf_we;
   logic [versat_pkg::ADDR_W-1:0] buf_waddr;
   logic [versat_pkg::DATA_W-1:0] buf_wdata;
   logic                          buf_re;
   logic [versat_pkg::ADDR_W-1:0] buf_raddr;
   logic [versat_pkg::DATA_W-1:0] buf_rdata;

   vwrite_unit u_unit (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .running_i   (running_i),
      .ping_pong_i (ping_pong_i),
      .store_cfg_i (store_cfg_i),
      .xfer_cfg_i  (xfer_cfg_i),
      .in_data_i   (in_data_i),
      .done_o      (done_o),
      .bus_req_o   (bus_req_o),
      .bus_rsp_i   (bus_rsp_i),
      .buf_we_o    (buf_we),
      .buf_waddr_o (buf_waddr),
      .buf_wdata_o (buf_wdata),
      .buf_re_o    (buf_re),
      .buf_raddr_o (buf_raddr),
      .buf_rdata_i (buf_rdata)
   );

   // both ping-pong halves live in the one buffer
   dp_buffer u_buffer (
      .clk     (clk),
      .we_i    (buf_we),
      .waddr_i (buf_waddr),
      .wdata_i (buf_wdata),
      .re_i    (buf_re),
      .raddr_i (buf_raddr),
      .rdata_o (buf_rdata)
   );

endmodule

/* vwrite_unit.sv */
module vwrite_unit (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run_i,
   input  logic                          running_i,
   input  logic                          ping_pong_i,
   input  versat_pkg::store_cfg_t        store_cfg_i,
   input  versat_pkg::xfer_cfg_t         xfer_cfg_i,
   input  logic [versat_pkg::DATA_W-1:0] in_data_i,
   output logic                          done_o,
   output versat_pkg::databus_req_t      bus_req_o,
   input  versat_pkg::databus_rsp_t      bus_rsp_i,
   output logic                          buf_we_o,
   output logic [versat_pkg::ADDR_W-1:0] buf_waddr_o,
   output logic [versat_pkg::DATA_W-1:0] buf_wdata_o,
   output logic                          buf_re_o,
   output logic [versat_pkg::ADDR_W-1:0] buf_raddr_o,
   input  logic [versat_pkg::DATA_W-1:0] buf_rdata_i
);

   logic                          store_done_q;
   logic                          pp_state_q;
   logic                          gen_valid;
   logic [versat_pkg::ADDR_W-1:0] gen_addr;
   logic                          gen_done;
   logic                          xfer_valid_q;
   logic [versat_pkg::ADDR_W-1:0] xfer_addr_q;
   logic [versat_pkg::ADDR_W-1:0] xfer_addr;
   logic                          xfer_ready;
   logic                          xfer_start;
   logic                          flush;
   logic                          rd_valid;
   logic                          rd_ready;
   logic [versat_pkg::DATA_W-1:0] rd_data;
   logic                          bw_done;
   logic                          xfer_done;

   assign xfer_start = run_i && xfer_cfg_i.enabled;

   // drop in-flight words on a new run or when the accelerator stops
   assign flush = !running_i || run_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         store_done_q <= 1'b1;
      end else if (run_i) begin
         store_done_q <= 1'b0;
      end else if (gen_done) begin
         store_done_q <= 1'b1;
      end
   end

   // halves swap on every run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state_q <= 1'b0;
      end else if (run_i) begin
         pp_state_q <= ping_pong_i ? !pp_state_q : 1'b0;
      end
   end

   // transfer address counter, one word per accepted address
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         xfer_valid_q <= 1'b0;
         xfer_addr_q  <= '0;
      end else if (run_i) begin
         xfer_valid_q <= xfer_cfg_i.enabled;
         xfer_addr_q  <= '0;
      end else if (!running_i) begin
         xfer_valid_q <= 1'b0;
      end else if (xfer_valid_q && xfer_ready) begin
         xfer_addr_q <= xfer_addr_q + 1'b1;
         if (xfer_addr_q == xfer_cfg_i.amount_minus_one) begin
            xfer_valid_q <= 1'b0;
         end
      end
   end

   // transfer reads the half stored by the previous run
   assign xfer_addr = {ping_pong_i ? !pp_state_q : xfer_addr_q[versat_pkg::ADDR_W-1],
                       xfer_addr_q[versat_pkg::ADDR_W-2:0]};

   addr_gen u_addr_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .cfg_i   (store_cfg_i),
      .valid_o (gen_valid),
      .addr_o  (gen_addr),
      .done_o  (gen_done)
   );

   assign buf_we_o    = gen_valid;
   assign buf_waddr_o = {ping_pong_i ? pp_state_q : gen_addr[versat_pkg::ADDR_W-1],
                         gen_addr[versat_pkg::ADDR_W-2:0]};
   assign buf_wdata_o = in_data_i;

   mem_reader u_mem_reader (
      .clk        (clk),
      .rst        (rst),
      .flush_i    (flush),
      .s_valid_i  (xfer_valid_q),
      .s_ready_o  (xfer_ready),
      .s_addr_i   (xfer_addr),
      .m_valid_o  (rd_valid),
      .m_ready_i  (rd_ready),
      .m_data_o   (rd_data),
      .mem_en_o   (buf_re_o),
      .mem_addr_o (buf_raddr_o),
      .mem_data_i (buf_rdata_i)
   );

   burst_writer u_burst_writer (
      .clk          (clk),
      .rst          (rst),
      .start_i      (xfer_start),
      .cfg_i        (xfer_cfg_i),
      .data_valid_i (rd_valid),
      .data_i       (rd_data),
      .data_ready_o (rd_ready),
      .bus_req_o    (bus_req_o),
      .bus_rsp_i    (bus_rsp_i),
      .done_o       (bw_done)
   );

   // no transfer means nothing to wait for
   assign xfer_done = bw_done || !xfer_cfg_i.enabled;
   assign done_o    = store_done_q && xfer_done;

endmodule

/* dp_buffer.sv */
module dp_buffer (
   input  logic                          clk,
   input  logic                          we_i,
   input  logic [versat_pkg::ADDR_W-1:0] waddr_i,
   input  logic [versat_pkg::DATA_W-1:0] wdata_i,
   input  logic                          re_i,
   input  logic [versat_pkg::ADDR_W-1:0] raddr_i,
   output logic [versat_pkg::DATA_W-1:0] rdata_o
);

   logic [versat_pkg::DATA_W-1:0] mem [2**versat_pkg::ADDR_W];
   logic [versat_pkg::DATA_W-1:0] rdata_q;

   // store side
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // transfer side, data one cycle after the enable
   always_ff @(posedge clk) begin
      if (re_i) begin
         rdata_q <= mem[raddr_i];
      end
   end

   assign rdata_o = rdata_q;

endmodule

/* burst_writer.sv */
module burst_writer (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          start_i,
   input  versat_pkg::xfer_cfg_t         cfg_i,
   input  logic                          data_valid_i,
   input  logic [versat_pkg::DATA_W-1:0] data_i,
   output logic                          data_ready_o,
   output versat_pkg::databus_req_t      bus_req_o,
   input  versat_pkg::databus_rsp_t      bus_rsp_i,
   output logic                          done_o
);

   logic                              active_q;
   logic                              done_q;
   logic [versat_pkg::ADDR_W:0]       words_left_q;
   logic [versat_pkg::EXT_ADDR_W-1:0] burst_addr_q;
   logic [versat_pkg::ADDR_W:0]       length_ext;
   logic [versat_pkg::LEN_W-1:0]      cur_len;
   logic [versat_pkg::ADDR_W:0]       cur_len_ext;
   logic [versat_pkg::EXT_ADDR_W-1:0] cur_len_words;
   logic [versat_pkg::EXT_ADDR_W-1:0] burst_bytes;
   logic                              beat;
   logic                              burst_end;

   assign length_ext = {{(versat_pkg::ADDR_W + 1 - versat_pkg::LEN_W){1'b0}}, cfg_i.length};

   // last burst carries whatever is left
   always_comb begin
      if (words_left_q < length_ext) begin
         cur_len = words_left_q[versat_pkg::LEN_W-1:0];
      end else begin
         cur_len = cfg_i.length;
      end
   end

   assign cur_len_ext   = {{(versat_pkg::ADDR_W + 1 - versat_pkg::LEN_W){1'b0}}, cur_len};
   assign cur_len_words = {{(versat_pkg::EXT_ADDR_W - versat_pkg::LEN_W){1'b0}}, cur_len};
   assign burst_bytes   = cur_len_words * versat_pkg::BYTES_PER_WORD;

   assign data_ready_o = active_q && bus_rsp_i.ready;
   assign beat         = bus_req_o.valid && bus_rsp_i.ready;
   assign burst_end    = beat && bus_rsp_i.last;

   // len is counted in words
   assign bus_req_o.valid = active_q && data_valid_i;
   assign bus_req_o.addr  = burst_addr_q;
   assign bus_req_o.wdata = data_i;
   assign bus_req_o.wstrb = '1;
   assign bus_req_o.len   = cur_len;

   assign done_o = done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active_q     <= 1'b0;
         done_q       <= 1'b1;
         words_left_q <= '0;
         burst_addr_q <= '0;
      end else if (start_i) begin
         active_q     <= 1'b1;
         done_q       <= 1'b0;
         words_left_q <= {1'b0, cfg_i.amount_minus_one} + 1'b1;
         burst_addr_q <= cfg_i.ext_addr;
      end else if (burst_end) begin
         words_left_q <= words_left_q - cur_len_ext;
         burst_addr_q <= burst_addr_q + burst_bytes;
         if (words_left_q == cur_len_ext) begin
            active_q <= 1'b0;
            done_q   <= 1'b1;
         end
      end
   end

endmodule

/* mem_reader.sv */
module mem_reader (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          flush_i,
   input  logic                          s_valid_i,
   output logic                          s_ready_o,
   input  logic [versat_pkg::ADDR_W-1:0] s_addr_i,
   output logic                          m_valid_o,
   input  logic                          m_ready_i,
   output logic [versat_pkg::DATA_W-1:0] m_data_o,
   output logic                          mem_en_o,
   output logic [versat_pkg::ADDR_W-1:0] mem_addr_o,
   input  logic [versat_pkg::DATA_W-1:0] mem_data_i
);

   logic                          out_valid_q;
   logic                          skid_valid_q;
   logic                          pend_q;
   logic [versat_pkg::DATA_W-1:0] out_data_q;
   logic [versat_pkg::DATA_W-1:0] skid_data_q;
   logic [1:0]                    fill;
   logic                          pop;
   logic                          accept;
   logic                          out_free;

   // words held or in flight, never above two
   assign fill = out_valid_q + skid_valid_q + pend_q;
   assign pop  = out_valid_q && m_ready_i;

   // room if below two, or if a word leaves this cycle
   assign s_ready_o = !flush_i && ((fill != 2'd2) || pop);
   assign accept    = s_valid_i && s_ready_o;
   assign out_free  = pop || !out_valid_q;

   assign mem_en_o   = accept;
   assign mem_addr_o = s_addr_i;
   assign m_valid_o  = out_valid_q;
   assign m_data_o   = out_data_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_q  <= 1'b0;
         skid_valid_q <= 1'b0;
         pend_q       <= 1'b0;
      end else if (flush_i) begin
         out_valid_q  <= 1'b0;
         skid_valid_q <= 1'b0;
         pend_q       <= 1'b0;
      end else begin
         pend_q <= accept;
         if (out_free) begin
            // skid word is older than the one returning now
            out_valid_q  <= skid_valid_q || pend_q;
            skid_valid_q <= 1'b0;
         end else if (pend_q) begin
            skid_valid_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (out_free) begin
         out_data_q <= skid_valid_q ? skid_data_q : mem_data_i;
      end else if (pend_q) begin
         skid_data_q <= mem_data_i;
      end
   end

endmodule

/* addr_gen.sv */
module addr_gen (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run_i,
   input  versat_pkg::store_cfg_t        cfg_i,
   output logic                          valid_o,
   output logic [versat_pkg::ADDR_W-1:0] addr_o,
   output logic                          done_o
);

   logic                            busy_q;
   logic                            done_q;
   logic [versat_pkg::DELAY_W-1:0]  delay_q;
   logic [versat_pkg::PERIOD_W-1:0] inner_q;
   logic [versat_pkg::ADDR_W-1:0]   outer_q;
   logic [versat_pkg::ADDR_W-1:0]   addr_q;
   logic [versat_pkg::ADDR_W-1:0]   base_q;
   logic [versat_pkg::ADDR_W-1:0]   next_base;
   logic                            step;
   logic                            inner_last;
   logic                            outer_last;

   // one address per cycle once the delay has run out
   assign step = busy_q && (delay_q == '0);

   // a period or iteration count of zero acts like one
   assign inner_last = (inner_q + 1'b1 >= cfg_i.per);
   assign outer_last = (outer_q + 1'b1 >= cfg_i.iter);

   assign next_base = base_q + cfg_i.shift;

   assign valid_o = step;
   assign addr_o  = addr_q;
   assign done_o  = done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy_q  <= 1'b0;
         done_q  <= 1'b1;
         delay_q <= '0;
         inner_q <= '0;
         outer_q <= '0;
      end else if (run_i) begin
         busy_q  <= 1'b1;
         done_q  <= 1'b0;
         delay_q <= cfg_i.delay;
         inner_q <= '0;
         outer_q <= '0;
      end else if (busy_q) begin
         if (delay_q != '0) begin
            delay_q <= delay_q - 1'b1;
         end else if (!inner_last) begin
            inner_q <= inner_q + 1'b1;
         end else if (!outer_last) begin
            inner_q <= '0;
            outer_q <= outer_q + 1'b1;
         end else begin
            // last address of the outer loop went out this cycle
            busy_q <= 1'b0;
            done_q <= 1'b1;
         end
      end
   end

   // running address, base tracks start + i*shift
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr_q <= cfg_i.start;
         base_q <= cfg_i.start;
      end else if (step) begin
         if (!inner_last) begin
            addr_q <= addr_q + cfg_i.incr;
         end else begin
            base_q <= next_base;
            addr_q <= next_base;
         end
      end
   end

endmodule

/* versat_pkg.sv */
package versat_pkg;

   // word width shared by the input stream, buffer and databus
   localparam int DATA_W = 32;

   // buffer address, top bit picks the ping-pong half
   localparam int ADDR_W = 10;

   localparam int PERIOD_W = 8;
   localparam int DELAY_W  = 8;

   // burst length in words
   localparam int LEN_W = 8;

   localparam int EXT_ADDR_W = 32;
   localparam int unsigned BYTES_PER_WORD = 4;

   // store side loops
   typedef struct packed {
      logic [ADDR_W-1:0]   start;
      logic [PERIOD_W-1:0] per;
      logic [ADDR_W-1:0]   incr;
      logic [ADDR_W-1:0]   iter;
      logic [ADDR_W-1:0]   shift;
      logic [DELAY_W-1:0]  delay;
   } store_cfg_t;

   // transfer side, word count is amount_minus_one + 1
   typedef struct packed {
      logic [EXT_ADDR_W-1:0] ext_addr;
      logic [ADDR_W-1:0]     amount_minus_one;
      logic [LEN_W-1:0]      length;
      logic                  enabled;
   } xfer_cfg_t;

   // unit to memory
   typedef struct packed {
      logic                  valid;
      logic [EXT_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     wdata;
      logic [DATA_W/8-1:0]   wstrb;
      logic [LEN_W-1:0]      len;
   } databus_req_t;

   // memory to unit, last comes with ready on the final beat
   typedef struct packed {
      logic ready;
      logic last;
   } databus_rsp_t;

endpackage
